//--- Bender.yml
package:
  name: mem_subsystem

sources:
  - include_dirs:
      - common
    files:
      - common/mem_pkg.sv
      - arbiter/mem_arbiter.sv
      - verilog/bus_port_merge.sv
      - verilog/sram_like_ram.sv
      - verilog/mem_subsystem.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/mem_subsystem_props.sv
      - dv/mem_subsystem_tb.sv

//--- arbiter/mem_arbiter.sv
`include "mem_params.svh"

module mem_arbiter (
    input  logic                   clk,
    input  logic                   resetn,

    output logic                   stall,

    input  logic                   inst_cache_req,
    input  logic [`MEM_ADDR_W-1:0] inst_cache_addr,
    output logic [`MEM_DATA_W-1:0] inst_cache_rdata,
    output logic                   inst_cache_dok,

    input  logic                   data_cache_req,
    input  logic [3:0]             data_cache_wen,
    input  logic [`MEM_ADDR_W-1:0] data_cache_addr,
    input  logic [`MEM_DATA_W-1:0] data_cache_wdata,
    output logic [`MEM_DATA_W-1:0] data_cache_rdata,
    output logic                   data_cache_dok,

    output logic                   inst_req,
    output logic                   inst_wr,
    output mem_pkg::access_size_t  inst_size,
    output logic [`MEM_ADDR_W-1:0] inst_addr,
    output logic [`MEM_DATA_W-1:0] inst_wdata,
    input  logic [`MEM_DATA_W-1:0] inst_rdata,
    input  logic                   inst_addr_ok,
    input  logic                   inst_data_ok,

    output logic                   data_req,
    output logic                   data_wr,
    output mem_pkg::access_size_t  data_size,
    output logic [`MEM_ADDR_W-1:0] data_addr,
    output logic [`MEM_DATA_W-1:0] data_wdata,
    input  logic [`MEM_DATA_W-1:0] data_rdata,
    input  logic                   data_addr_ok,
    input  logic                   data_data_ok
);

    mem_pkg::arb_state_t    state;
    mem_pkg::access_size_t  data_size_dec;
    logic                   inst_valid;
    logic                   data_valid;
    logic                   pend_inst;     // inst owed after a data+inst pair
    logic                   dok_busy;
    logic                   inst_dok_q;
    logic                   data_dok_q;
    logic [`MEM_DATA_W-1:0] inst_rdata_q;
    logic [`MEM_DATA_W-1:0] data_rdata_q;

    // byte enables to transfer size
    always_comb begin
        case (data_cache_wen)
            4'b0000, 4'b1111:                   data_size_dec = mem_pkg::size_word;
            4'b0001, 4'b0010, 4'b0100, 4'b1000: data_size_dec = mem_pkg::size_byte;
            4'b0011, 4'b1100:                   data_size_dec = mem_pkg::size_half;
            default:                            data_size_dec = mem_pkg::size_illegal;
        endcase
    end

    assign inst_valid = inst_cache_req && (inst_cache_addr[1:0] == 2'b00);
    assign data_valid = data_cache_req && (data_size_dec != mem_pkg::size_illegal);

    // cache still holds its req while dok is out, don't restart it
    assign dok_busy = inst_dok_q || data_dok_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= mem_pkg::arb_idle;
            pend_inst <= 1'b0;
        end else begin
            case (state)
                mem_pkg::arb_idle: begin
                    if (!dok_busy) begin
                        if (data_valid) begin
                            state     <= mem_pkg::arb_data_issue;
                            pend_inst <= inst_valid;
                        end else if (inst_valid) begin
                            state <= mem_pkg::arb_inst_issue;
                        end
                    end
                end
                mem_pkg::arb_inst_issue: if (inst_addr_ok) state <= mem_pkg::arb_inst_wait;
                mem_pkg::arb_inst_wait:  if (inst_data_ok) state <= mem_pkg::arb_idle;
                mem_pkg::arb_data_issue: if (data_addr_ok) state <= mem_pkg::arb_data_wait;
                mem_pkg::arb_data_wait: begin
                    if (data_data_ok) begin
                        state     <= pend_inst ? mem_pkg::arb_inst_issue : mem_pkg::arb_idle;
                        pend_inst <= 1'b0;
                    end
                end
                default: state <= mem_pkg::arb_idle;
            endcase
        end
    end

    // one-cycle dok after data_ok
    always_ff @(posedge clk) begin
        if (!resetn) begin
            inst_dok_q <= 1'b0;
            data_dok_q <= 1'b0;
        end else begin
            inst_dok_q <= (state == mem_pkg::arb_inst_wait) && inst_data_ok;
            data_dok_q <= (state == mem_pkg::arb_data_wait) && data_data_ok;
        end
    end

    always_ff @(posedge clk) begin
        if ((state == mem_pkg::arb_inst_wait) && inst_data_ok)
            inst_rdata_q <= inst_rdata;
        if ((state == mem_pkg::arb_data_wait) && data_data_ok)
            data_rdata_q <= data_rdata;
    end

    assign inst_cache_rdata = inst_rdata_q;
    assign inst_cache_dok   = inst_dok_q;
    assign data_cache_rdata = data_rdata_q;
    assign data_cache_dok   = data_dok_q;

    assign stall = (state != mem_pkg::arb_idle);

    // fetch is always a word read
    assign inst_req   = (state == mem_pkg::arb_inst_issue);
    assign inst_wr    = 1'b0;
    assign inst_size  = mem_pkg::size_word;
    assign inst_addr  = inst_cache_addr;
    assign inst_wdata = '0;

    assign data_req   = (state == mem_pkg::arb_data_issue);
    assign data_wr    = |data_cache_wen;
    assign data_size  = data_size_dec;
    assign data_addr  = data_cache_addr;
    assign data_wdata = data_cache_wdata;

endmodule

//--- common/mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// bus widths
`define MEM_ADDR_W 32
`define MEM_DATA_W 32

// on-chip ram depth, in words
`define RAM_WORDS_LOG2 10

// default ram wait states
`define RAM_ADDR_WAIT 1
`define RAM_DATA_WAIT 2

`endif

//--- common/mem_pkg.sv
package mem_pkg;

    // bus transfer size, same encoding as the SRAM-like size field
    typedef enum logic [1:0] {
        size_byte    = 2'b00,
        size_half    = 2'b01,
        size_word    = 2'b10,
        size_illegal = 2'b11   // wen pattern the bus cannot express
    } access_size_t;

    // arbiter FSM
    typedef enum logic [2:0] {
        arb_idle       = 3'd0,
        arb_inst_issue = 3'd1,  // inst_req high, waiting for addr_ok
        arb_inst_wait  = 3'd2,  // accepted, waiting for data_ok
        arb_data_issue = 3'd3,
        arb_data_wait  = 3'd4
    } arb_state_t;

endpackage

//--- dv/mem_stimulus.txt
# kind inst_addr data_addr wen wdata exp_inst_rdata exp_data_rdata inst_dok data_dok
# values in hex, dok flags decimal; wen 0 is a read, data rdata checked on reads only
data 00000000 00000010 f 12345678 00000000 00000000 0 1
data 00000000 00000010 0 00000000 00000000 12345678 0 1
data 00000000 00000014 f aabbccdd 00000000 00000000 0 1
data 00000000 00000015 2 0000ee00 00000000 00000000 0 1
data 00000000 00000016 c 77660000 00000000 00000000 0 1
data 00000000 00000014 0 00000000 00000000 7766eedd 0 1
data 00000000 00000020 3 0000beef 00000000 00000000 0 1
data 00000000 00000023 8 5a000000 00000000 00000000 0 1
data 00000000 00000020 0 00000000 00000000 5a00beef 0 1
inst 00000010 00000000 0 00000000 12345678 00000000 1 0
pair 00000014 00000020 0 00000000 7766eedd 5a00beef 1 1
pair 00000030 00000030 f 0badf00d 0badf00d 00000000 1 1
inst 00000012 00000000 0 00000000 00000000 00000000 0 0
data 00000000 00000040 5 11223344 00000000 00000000 0 0
data 00000000 00000040 0 00000000 00000000 00000000 0 1

//--- dv/mem_subsystem_props.sv
`include "mem_params.svh"

module mem_subsystem_props (
    input logic                   clk,
    input logic                   resetn,
    input logic                   stall,
    input mem_pkg::arb_state_t    state,
    input logic                   inst_req,
    input logic [`MEM_ADDR_W-1:0] inst_addr,
    input logic                   inst_addr_ok,
    input logic                   inst_data_ok,
    input logic                   data_req,
    input logic                   data_wr,
    input mem_pkg::access_size_t  data_size,
    input logic [`MEM_ADDR_W-1:0] data_addr,
    input logic [`MEM_DATA_W-1:0] data_wdata,
    input logic                   data_addr_ok,
    input logic                   data_data_ok,
    input logic                   inst_cache_dok,
    input logic                   data_cache_dok
);

    int   fail_count = 0;
    logic outstanding;   // accepted, data_ok not seen yet

    task automatic record_failure(input string what);
        fail_count++;
        $error("%s", what);
    endtask

    always_ff @(posedge clk) begin
        if (!resetn)
            outstanding <= 1'b0;
        else if ((inst_req && inst_addr_ok) || (data_req && data_addr_ok))
            outstanding <= 1'b1;
        else if (inst_data_ok || data_data_ok)
            outstanding <= 1'b0;
    end

    one_port: assert property (@(posedge clk) disable iff (!resetn)
        outstanding |-> !(inst_req || data_req))
        else record_failure("bus request while another transfer is outstanding");

    inst_hold: assert property (@(posedge clk) disable iff (!resetn)
        inst_req && !inst_addr_ok |=> inst_req && $stable(inst_addr))
        else record_failure("inst bus request changed before addr_ok");

    data_hold: assert property (@(posedge clk) disable iff (!resetn)
        data_req && !data_addr_ok |=> data_req
            && $stable({data_wr, data_size, data_addr, data_wdata}))
        else record_failure("data bus request changed before addr_ok");

    inst_dok_pulse: assert property (@(posedge clk) disable iff (!resetn)
        inst_cache_dok |=> !inst_cache_dok)
        else record_failure("inst_cache_dok longer than one cycle");

    data_dok_pulse: assert property (@(posedge clk) disable iff (!resetn)
        data_cache_dok |=> !data_cache_dok)
        else record_failure("data_cache_dok longer than one cycle");

    // idle and not stalled straight out of reset
    reset_idle: assert property (@(posedge clk)
        !resetn |=> !stall && state == mem_pkg::arb_idle)
        else record_failure("arbiter not idle after reset");

endmodule

bind mem_arbiter mem_subsystem_props u_props (.*);

//--- dv/mem_subsystem_tb.sv
`include "mem_params.svh"

module mem_subsystem_tb;

    localparam int drop_window = 20;  // cycles allowed for a request that must be dropped

    logic                   clk = 1'b0;
    logic                   resetn;
    logic                   stall;
    logic                   inst_cache_req;
    logic [`MEM_ADDR_W-1:0] inst_cache_addr;
    logic [`MEM_DATA_W-1:0] inst_cache_rdata;
    logic                   inst_cache_dok;
    logic                   data_cache_req;
    logic [3:0]             data_cache_wen;
    logic [`MEM_ADDR_W-1:0] data_cache_addr;
    logic [`MEM_DATA_W-1:0] data_cache_wdata;
    logic [`MEM_DATA_W-1:0] data_cache_rdata;
    logic                   data_cache_dok;

    string lines[$];
    bit    loaded = 1'b0;

    mem_subsystem dut (.*);

    always #20 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
            abort_run($sformatf("Fail: %s = %h, expected %h", name, got, exp));
    endtask

    task automatic load_stimulus();
        int    fd;
        string line;
        fd = $fopen("dv/mem_stimulus.txt", "r");
        if (fd == 0)
            abort_run("could not open the stimulus file dv/mem_stimulus.txt");
        while (!$feof(fd)) begin
            if ($fgets(line, fd) && line.len() > 1 && line[0] != "#")
                lines.push_back(line);
        end
        $fclose(fd);
    endtask

    // one cache transaction: drive, wait for the doks, check data and stall
    task automatic run_line(input string line);
        string       kind;
        logic [31:0] i_addr, d_addr, wdata, exp_i, exp_d;
        logic [3:0]  wen;
        int          want_i, want_d, cyc;
        bit          seen_i, seen_d, pending;
        if ($sscanf(line, "%s %h %h %h %h %h %h %d %d", kind, i_addr, d_addr, wen, wdata,
                    exp_i, exp_d, want_i, want_d) != 9)
            abort_run({"malformed stimulus line: ", line});
        @(posedge clk);
        inst_cache_req   <= (kind != "data");
        inst_cache_addr  <= i_addr;
        data_cache_req   <= (kind != "inst");
        data_cache_wen   <= wen;
        data_cache_addr  <= d_addr;
        data_cache_wdata <= wdata;
        seen_i = 1'b0;
        seen_d = 1'b0;
        cyc    = 0;
        do begin
            @(negedge clk);
            cyc++;
            if (inst_cache_dok) begin
                check_value("inst_cache_dok", 1, want_i && !seen_i);
                check_value("inst_cache_rdata", inst_cache_rdata, exp_i);
                if (want_d && !seen_d)
                    abort_run("inst_cache_dok arrived before data_cache_dok in a pair");
                seen_i = 1'b1;
            end
            if (data_cache_dok) begin
                check_value("data_cache_dok", 1, want_d && !seen_d);
                if (wen == 4'h0)  // write data comes back stale
                    check_value("data_cache_rdata", data_cache_rdata, exp_d);
                seen_d = 1'b1;
            end
            pending = (want_i && !seen_i) || (want_d && !seen_d);
            check_value("stall", stall, cyc > 1 && pending);
            @(posedge clk);
            if (seen_i)
                inst_cache_req <= 1'b0;
            if (seen_d)
                data_cache_req <= 1'b0;
        end while (pending || (!want_i && !want_d && cyc < drop_window));
        inst_cache_req <= 1'b0;
        data_cache_req <= 1'b0;
        @(negedge clk);
        check_value("stall", stall, 0);  // cycle after the last dok
    endtask

    initial begin
        resetn           = 1'b0;
        inst_cache_req   = 1'b0;
        inst_cache_addr  = '0;
        data_cache_req   = 1'b0;
        data_cache_wen   = 4'h0;
        data_cache_addr  = '0;
        data_cache_wdata = '0;
        load_stimulus();
        loaded = 1'b1;
        repeat (16) @(posedge clk);
        resetn <= 1'b1;
        foreach (lines[i])
            run_line(lines[i]);
        $display("No errors");
        $finish;
    end

    // bound assertions count their failures
    always @(dut.u_arbiter.u_props.fail_count)
        if (dut.u_arbiter.u_props.fail_count != 0)
            abort_run("a bus protocol assertion failed");

    initial begin
        wait (loaded);
        repeat (16 + 40 * lines.size()) @(posedge clk);
        abort_run("timeout: the stimulus did not complete in time");
    end

endmodule

//--- verilog/bus_port_merge.sv
`include "mem_params.svh"

module bus_port_merge (
    input  logic                   clk,
    input  logic                   resetn,

    input  logic                   inst_req,
    input  logic                   inst_wr,
    input  mem_pkg::access_size_t  inst_size,
    input  logic [`MEM_ADDR_W-1:0] inst_addr,
    input  logic [`MEM_DATA_W-1:0] inst_wdata,
    output logic [`MEM_DATA_W-1:0] inst_rdata,
    output logic                   inst_addr_ok,
    output logic                   inst_data_ok,

    input  logic                   data_req,
    input  logic                   data_wr,
    input  mem_pkg::access_size_t  data_size,
    input  logic [`MEM_ADDR_W-1:0] data_addr,
    input  logic [`MEM_DATA_W-1:0] data_wdata,
    output logic [`MEM_DATA_W-1:0] data_rdata,
    output logic                   data_addr_ok,
    output logic                   data_data_ok,

    output logic                   ram_req,
    output logic                   ram_wr,
    output mem_pkg::access_size_t  ram_size,
    output logic [`MEM_ADDR_W-1:0] ram_addr,
    output logic [`MEM_DATA_W-1:0] ram_wdata,
    input  logic [`MEM_DATA_W-1:0] ram_rdata,
    input  logic                   ram_addr_ok,
    input  logic                   ram_data_ok
);

    logic sel_data;   // data wins if both request
    logic owner;      // 1 = data port owns the outstanding transfer

    assign sel_data = data_req;

    assign ram_req   = inst_req || data_req;
    assign ram_wr    = sel_data ? data_wr    : inst_wr;
    assign ram_size  = sel_data ? data_size  : inst_size;
    assign ram_addr  = sel_data ? data_addr  : inst_addr;
    assign ram_wdata = sel_data ? data_wdata : inst_wdata;

    assign data_addr_ok = ram_addr_ok && data_req;
    assign inst_addr_ok = ram_addr_ok && inst_req && !data_req;

    always_ff @(posedge clk) begin
        if (!resetn)
            owner <= 1'b0;
        else if (ram_req && ram_addr_ok)
            owner <= sel_data;  // latched at accept
    end

    assign inst_data_ok = ram_data_ok && !owner;
    assign data_data_ok = ram_data_ok && owner;
    assign inst_rdata   = owner ? '0 : ram_rdata;
    assign data_rdata   = owner ? ram_rdata : '0;

endmodule

//--- verilog/mem_subsystem.sv
`include "mem_params.svh"

module mem_subsystem (
    input  logic                   clk,
    input  logic                   resetn,

    output logic                   stall,

    input  logic                   inst_cache_req,
    input  logic [`MEM_ADDR_W-1:0] inst_cache_addr,
    output logic [`MEM_DATA_W-1:0] inst_cache_rdata,
    output logic                   inst_cache_dok,

    input  logic                   data_cache_req,
    input  logic [3:0]             data_cache_wen,
    input  logic [`MEM_ADDR_W-1:0] data_cache_addr,
    input  logic [`MEM_DATA_W-1:0] data_cache_wdata,
    output logic [`MEM_DATA_W-1:0] data_cache_rdata,
    output logic                   data_cache_dok
);

    // arbiter to merger
    logic                   inst_req, inst_wr, inst_addr_ok, inst_data_ok;
    mem_pkg::access_size_t  inst_size;
    logic [`MEM_ADDR_W-1:0] inst_addr;
    logic [`MEM_DATA_W-1:0] inst_wdata, inst_rdata;
    logic                   data_req, data_wr, data_addr_ok, data_data_ok;
    mem_pkg::access_size_t  data_size;
    logic [`MEM_ADDR_W-1:0] data_addr;
    logic [`MEM_DATA_W-1:0] data_wdata, data_rdata;

    // merger to ram
    logic                   ram_req, ram_wr, ram_addr_ok, ram_data_ok;
    mem_pkg::access_size_t  ram_size;
    logic [`MEM_ADDR_W-1:0] ram_addr;
    logic [`MEM_DATA_W-1:0] ram_wdata, ram_rdata;

    mem_arbiter u_arbiter (
        .clk, .resetn, .stall,
        .inst_cache_req, .inst_cache_addr, .inst_cache_rdata, .inst_cache_dok,
        .data_cache_req, .data_cache_wen, .data_cache_addr, .data_cache_wdata,
        .data_cache_rdata, .data_cache_dok,
        .inst_req, .inst_wr, .inst_size, .inst_addr, .inst_wdata,
        .inst_rdata, .inst_addr_ok, .inst_data_ok,
        .data_req, .data_wr, .data_size, .data_addr, .data_wdata,
        .data_rdata, .data_addr_ok, .data_data_ok
    );

    bus_port_merge u_merge (
        .clk, .resetn,
        .inst_req, .inst_wr, .inst_size, .inst_addr, .inst_wdata,
        .inst_rdata, .inst_addr_ok, .inst_data_ok,
        .data_req, .data_wr, .data_size, .data_addr, .data_wdata,
        .data_rdata, .data_addr_ok, .data_data_ok,
        .ram_req, .ram_wr, .ram_size, .ram_addr, .ram_wdata,
        .ram_rdata, .ram_addr_ok, .ram_data_ok
    );

    sram_like_ram u_ram (
        .clk, .resetn,
        .ram_req, .ram_wr, .ram_size, .ram_addr, .ram_wdata,
        .ram_rdata, .ram_addr_ok, .ram_data_ok
    );

endmodule

//--- verilog/sram_like_ram.sv
`include "mem_params.svh"

module sram_like_ram #(
    parameter int addr_wait = `RAM_ADDR_WAIT,
    parameter int data_wait = `RAM_DATA_WAIT
) (
    input  logic                   clk,
    input  logic                   resetn,

    input  logic                   ram_req,
    input  logic                   ram_wr,
    input  mem_pkg::access_size_t  ram_size,
    input  logic [`MEM_ADDR_W-1:0] ram_addr,
    input  logic [`MEM_DATA_W-1:0] ram_wdata,
    output logic [`MEM_DATA_W-1:0] ram_rdata,
    output logic                   ram_addr_ok,
    output logic                   ram_data_ok
);

    localparam int lanes  = `MEM_DATA_W / 8;
    localparam int depth  = 2 ** `RAM_WORDS_LOG2;
    localparam int acnt_w = (addr_wait > 0) ? $clog2(addr_wait + 1) : 1;
    localparam int dcnt_w = (data_wait > 0) ? $clog2(data_wait + 1) : 1;

    logic [`MEM_DATA_W-1:0]    mem [depth];
    logic [`MEM_DATA_W-1:0]    rdata_q;
    logic [acnt_w-1:0]         acnt;
    logic [dcnt_w-1:0]         dcnt;
    logic                      busy;      // accepted, data phase running
    logic                      accept;
    logic [`RAM_WORDS_LOG2-1:0] widx;
    logic [lanes-1:0]          be;

    initial begin
        for (int i = 0; i < depth; i++)
            mem[i] = '0;
    end

    assign widx        = ram_addr[`RAM_WORDS_LOG2+1:2];
    assign ram_addr_ok = ram_req && !busy && (acnt == acnt_w'(addr_wait));
    assign accept      = ram_addr_ok;
    assign ram_data_ok = busy && (dcnt == dcnt_w'(data_wait));
    assign ram_rdata   = rdata_q;

    // lanes written for each size
    always_comb begin
        case (ram_size)
            mem_pkg::size_byte: be = lanes'(1) << ram_addr[1:0];
            mem_pkg::size_half: be = ram_addr[1] ? 4'b1100 : 4'b0011;
            mem_pkg::size_word: be = '1;
            default:            be = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            acnt <= '0;
            dcnt <= '0;
            busy <= 1'b0;
        end else begin
            if (accept)
                acnt <= '0;
            else if (ram_req && !busy)
                acnt <= acnt + 1'b1;  // address wait

            if (accept) begin
                busy <= 1'b1;
                dcnt <= '0;
            end else if (ram_data_ok) begin
                busy <= 1'b0;
            end else if (busy) begin
                dcnt <= dcnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            if (ram_wr) begin
                for (int i = 0; i < lanes; i++)
                    if (be[i])
                        mem[widx][8*i +: 8] <= ram_wdata[8*i +: 8];
            end else begin
                rdata_q <= mem[widx];
            end
        end
    end

endmodule

//--- vlog.f
+incdir+common
common/mem_pkg.sv
arbiter/mem_arbiter.sv
verilog/bus_port_merge.sv
verilog/sram_like_ram.sv
verilog/mem_subsystem.sv
dv/mem_subsystem_props.sv
dv/mem_subsystem_tb.sv
